// ==== rtl/cpu_pkg.sv ====
// Core-wide definitions
package cpu_pkg;

    localparam logic [31:0] RESET_PC = 32'h0040_0000;   // first fetch address

    // primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;

    // R-type function field
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    // fault causes
    localparam logic [1:0] FAULT_NONE     = 2'd0;
    localparam logic [1:0] FAULT_ILLEGAL  = 2'd1;
    localparam logic [1:0] FAULT_OVERFLOW = 2'd2;

    // fault FSM states
    localparam logic ST_RUN  = 1'b0;
    localparam logic ST_HALT = 1'b1;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // one instruction word, two field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [4:0] rs;
        logic [4:0] rt;
        logic       uses_rs;
        logic       uses_rt;
    } src_use_t;

    // register producer seen in one stage
    typedef struct packed {
        logic [4:0] dest;
        logic       writes;
        logic       is_load;
    } dst_t;

    typedef struct packed {
        logic [1:0]  cause;
        logic [31:0] pc;
    } fault_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [4:0]  dest;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] imm;
        fault_t      fault;
    } id_ex_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [4:0]  dest;
        logic [31:0] alu_result;
        logic [31:0] store_data;
        fault_t      fault;
    } ex_mem_t;

    typedef struct packed {
        logic        reg_write;
        logic        is_load;
        logic [4:0]  dest;
        logic [31:0] alu_result;
        logic [31:0] load_data;
        fault_t      fault;
    } mem_wb_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
    } dmem_req_t;

    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } wb_write_t;

endpackage

// ==== rtl/hazard_counter.sv ====
// Stall counter for execute-stage producers
`timescale 1ns/100ps

module hazard_counter import cpu_pkg::*;
(
    input  logic     SYS_reset,
    input  logic     WB_exception_singal,
    input  logic     halted,
    input  src_use_t src_use,
    input  dst_t     ex_dst,
    output logic     stall
);

    logic [1:0] count;     // stall cycles left after this one
    logic [1:0] cur;       // stall cycles left including this one
    logic       depends;

    always_comb
    begin
        depends = ex_dst.writes &&
                  ((src_use.uses_rs && (src_use.rs == ex_dst.dest)) ||
                   (src_use.uses_rt && (src_use.rt == ex_dst.dest)));
        if (count != 2'd0)
            cur = count;
        else if (depends)
            cur = ex_dst.is_load ? 2'd2 : 2'd1;   // load data shows up one stage later
        else
            cur = 2'd0;
    end

    assign stall = (cur != 2'd0);

    always_ff @(posedge SYS_reset or posedge WB_exception_singal)
    begin
        if (WB_exception_singal)
            count <= 2'd0;
        else if (halted)
            count <= 2'd0;
        else if (cur != 2'd0)
            count <= cur - 2'd1;    // step down
        else
            count <= 2'd0;
    end

endmodule

// ==== rtl/fault_fsm.sv ====
// Fault capture and halt
`timescale 1ns/100ps

module fault_fsm import cpu_pkg::*;
(
    input  logic   SYS_reset,
    input  logic   WB_exception_singal,
    input  logic   fault_retire,
    input  fault_t retire_fault,
    output logic   halted,
    output fault_t fault_out
);

    logic state;

    always_ff @(posedge SYS_reset or posedge WB_exception_singal)
    begin
        if (WB_exception_singal)
        begin
            state     <= ST_RUN;
            fault_out <= '0;
        end
        else if ((state == ST_RUN) && fault_retire)
        begin
            state     <= ST_HALT;         // only reset leaves this state
            fault_out <= retire_fault;    // cause and pc of the retiring instruction
        end
    end

    assign halted = (state == ST_HALT);

endmodule

// ==== rtl/reg_file.sv ====
// General purpose register file
`timescale 1ns/100ps

module reg_file import cpu_pkg::*;
(
    input  logic        SYS_reset,
    input  logic        WB_exception_singal,
    input  logic [4:0]  rd_addr_a,
    input  logic [4:0]  rd_addr_b,
    output logic [31:0] rd_data_a,
    output logic [31:0] rd_data_b,
    input  wb_write_t   wb_write
);

    logic [31:0] regs [32];

    // r0 is hardwired, same-cycle write is bypassed to the reader
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0)
            return '0;
        else if (wb_write.en && (wb_write.addr == addr))
            return wb_write.data;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge SYS_reset or posedge WB_exception_singal)
    begin
        if (WB_exception_singal)
            regs <= '{default: '0};
        else if (wb_write.en && (wb_write.addr != 5'd0))
            regs[wb_write.addr] <= wb_write.data;
    end

    always_comb
    begin
        rd_data_a = read_port(rd_addr_a);
        rd_data_b = read_port(rd_addr_b);
    end

endmodule

// ==== rtl/decode_unit.sv ====
// Decode stage with branch resolution
`timescale 1ns/100ps

module decode_unit import cpu_pkg::*;
(
    input  logic        SYS_reset,
    input  logic        WB_exception_singal,
    input  instr_u      imem_data,
    input  logic [31:0] fetch_pc,
    input  logic        stall,
    input  logic        halted,
    input  wb_write_t   wb_write,
    input  dst_t        mem_dst,
    input  logic [31:0] mem_result,
    output src_use_t    src_use,
    output id_ex_t      id_ex,
    output logic        branch_taken,
    output logic [31:0] branch_target
);

    logic        valid;       // low for a bubble
    instr_u      instr;
    logic [31:0] pc;
    ctrl_t       ctrl;
    logic [4:0]  dest;
    logic        uses_rs;
    logic        uses_rt;
    logic        is_beq;
    logic        legal;
    logic [31:0] rf_a;
    logic [31:0] rf_b;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] imm;

    always_ff @(posedge SYS_reset or posedge WB_exception_singal)
    begin
        if (WB_exception_singal)
        begin
            valid <= 1'b0;
            instr <= '0;
            pc    <= '0;
        end
        else if (halted)
            valid <= 1'b0;
        else if (!stall)
        begin
            valid <= !branch_taken;   // squash the word fetched behind a taken beq
            instr <= imem_data;
            pc    <= fetch_pc;
        end
    end

    always_comb
    begin
        ctrl    = '0;
        dest    = instr.i.rt;
        uses_rs = 1'b0;
        uses_rt = 1'b0;
        is_beq  = 1'b0;
        legal   = 1'b1;
        case (instr.r.opcode)
            OP_RTYPE:
            begin
                dest           = instr.r.rd;
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
                ctrl.reg_write = 1'b1;
                case (instr.r.funct)
                    FN_ADD:  ctrl.alu_op = ALU_ADD;
                    FN_SUB:  ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: legal = 1'b0;
                endcase
            end
            OP_ADDI:
            begin
                uses_rs          = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_LW:
            begin
                uses_rs          = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_SW:
            begin
                uses_rs          = 1'b1;
                uses_rt          = 1'b1;   // store data
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_BEQ:
            begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                is_beq  = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        if (!valid)
            legal = 1'b1;
        if (!valid || !legal)
        begin
            ctrl    = '0;
            uses_rs = 1'b0;
            uses_rt = 1'b0;
            is_beq  = 1'b0;
        end
    end

    reg_file u_reg_file (
        .SYS_reset           (SYS_reset),
        .WB_exception_singal (WB_exception_singal),
        .rd_addr_a           (instr.r.rs),
        .rd_addr_b           (instr.r.rt),
        .rd_data_a           (rf_a),
        .rd_data_b           (rf_b),
        .wb_write            (wb_write)
    );

    // memory stage result wins over the register file
    assign op_a = (mem_dst.writes && (mem_dst.dest == instr.r.rs)) ? mem_result : rf_a;
    assign op_b = (mem_dst.writes && (mem_dst.dest == instr.r.rt)) ? mem_result : rf_b;
    assign imm  = {{16{instr.i.imm[15]}}, instr.i.imm};

    assign branch_taken  = is_beq && (op_a == op_b) && !stall && !halted;
    assign branch_target = pc + 32'd4 + {imm[29:0], 2'b00};

    assign src_use = '{rs: instr.r.rs, rt: instr.r.rt, uses_rs: uses_rs, uses_rt: uses_rt};

    always_comb
    begin
        id_ex = '0;   // bubble while stalled
        if (!stall)
        begin
            id_ex.ctrl        = ctrl;
            id_ex.dest        = dest;
            id_ex.op_a        = op_a;
            id_ex.op_b        = op_b;
            id_ex.imm         = imm;
            id_ex.fault.cause = legal ? FAULT_NONE : FAULT_ILLEGAL;
            id_ex.fault.pc    = pc;
        end
    end

endmodule

// ==== rtl/execute_unit.sv ====
// Execute stage with ALU
`timescale 1ns/100ps

module execute_unit import cpu_pkg::*;
(
    input  logic    SYS_reset,
    input  logic    WB_exception_singal,
    input  logic    halted,
    input  id_ex_t  id_ex,
    output dst_t    ex_dst,
    output ex_mem_t ex_mem
);

    id_ex_t      ex_q;
    logic [31:0] op_a;
    logic [31:0] alu_b;
    logic [31:0] sum;
    logic [31:0] diff;
    logic [31:0] result;
    logic        ovf_raw;
    logic        overflow;

    always_ff @(posedge SYS_reset or posedge WB_exception_singal)
    begin
        if (WB_exception_singal)
            ex_q <= '0;
        else if (halted)
            ex_q <= '0;
        else
            ex_q <= id_ex;
    end

    assign op_a  = ex_q.op_a;
    assign alu_b = ex_q.ctrl.alu_src_imm ? ex_q.imm : ex_q.op_b;
    assign sum   = op_a + alu_b;
    assign diff  = op_a - alu_b;

    always_comb
    begin
        result  = '0;
        ovf_raw = 1'b0;
        case (ex_q.ctrl.alu_op)
            ALU_ADD:
            begin
                result  = sum;
                ovf_raw = (op_a[31] == alu_b[31]) && (sum[31] != op_a[31]);
            end
            ALU_SUB:
            begin
                result  = diff;
                ovf_raw = (op_a[31] != alu_b[31]) && (diff[31] != op_a[31]);
            end
            ALU_AND: result = op_a & alu_b;
            ALU_OR:  result = op_a | alu_b;
            ALU_SLT: result = {31'd0, $signed(op_a) < $signed(alu_b)};
            default: result = '0;
        endcase
    end

    // address math of lw and sw never faults
    assign overflow = ovf_raw && ex_q.ctrl.reg_write && !ex_q.ctrl.mem_read;

    always_comb
    begin
        ex_mem.ctrl       = ex_q.ctrl;
        ex_mem.dest       = ex_q.dest;
        ex_mem.alu_result = result;
        ex_mem.store_data = ex_q.op_b;
        ex_mem.fault      = ex_q.fault;
        if (ex_q.fault.cause != FAULT_NONE)
            ex_mem.ctrl = '0;                          // older fault keeps its cause
        else if (overflow)
        begin
            ex_mem.ctrl        = '0;
            ex_mem.fault.cause = FAULT_OVERFLOW;
        end
    end

    assign ex_dst.dest    = ex_mem.dest;
    assign ex_dst.writes  = ex_mem.ctrl.reg_write && (ex_mem.dest != 5'd0);
    assign ex_dst.is_load = ex_mem.ctrl.mem_read;

endmodule

// ==== rtl/mem_wb_unit.sv ====
// Memory and writeback stages
`timescale 1ns/100ps

module mem_wb_unit import cpu_pkg::*;
(
    input  logic        SYS_reset,
    input  logic        WB_exception_singal,
    input  logic        halted,
    input  ex_mem_t     ex_mem,
    input  logic [31:0] dmem_rdata,
    output dmem_req_t   dmem_req,
    output dst_t        mem_dst,
    output logic [31:0] mem_result,
    output wb_write_t   wb_write,
    output logic        fault_retire,
    output fault_t      retire_fault
);

    ex_mem_t mem_q;
    mem_wb_t wb_q;
    mem_wb_t wb_next;
    logic    wb_fault;

    assign wb_fault = (wb_q.fault.cause != FAULT_NONE);

    always_comb
    begin
        wb_next.reg_write  = mem_q.ctrl.reg_write;
        wb_next.is_load    = mem_q.ctrl.mem_read;
        wb_next.dest       = mem_q.dest;
        wb_next.alu_result = mem_q.alu_result;
        wb_next.load_data  = dmem_rdata;
        wb_next.fault      = mem_q.fault;
    end

    // younger work is dropped once a fault sits in writeback
    always_ff @(posedge SYS_reset or posedge WB_exception_singal)
    begin
        if (WB_exception_singal)
        begin
            mem_q <= '0;
            wb_q  <= '0;
        end
        else if (halted || wb_fault)
        begin
            mem_q <= '0;
            wb_q  <= '0;
        end
        else
        begin
            mem_q <= ex_mem;
            wb_q  <= wb_next;
        end
    end

    assign dmem_req.addr  = mem_q.alu_result;
    assign dmem_req.wdata = mem_q.store_data;
    assign dmem_req.we    = mem_q.ctrl.mem_write && !wb_fault;   // no store behind a fault

    assign mem_dst.dest    = mem_q.dest;
    assign mem_dst.writes  = mem_q.ctrl.reg_write && (mem_q.dest != 5'd0);
    assign mem_dst.is_load = mem_q.ctrl.mem_read;
    assign mem_result      = mem_q.ctrl.mem_read ? dmem_rdata : mem_q.alu_result;

    assign wb_write.en   = wb_q.reg_write;
    assign wb_write.addr = wb_q.dest;
    assign wb_write.data = wb_q.is_load ? wb_q.load_data : wb_q.alu_result;

    assign fault_retire = wb_fault;     // one cycle, the stage is flushed behind it
    assign retire_fault = wb_q.fault;

endmodule

// ==== rtl/mips_core.sv ====
// Five-stage pipelined core
`timescale 1ns/100ps

module mips_core import cpu_pkg::*;
(
    input  logic        SYS_reset,
    input  logic        WB_exception_singal,
    output logic [31:0] imem_addr,
    input  instr_u      imem_data,
    output dmem_req_t   dmem_req,
    input  logic [31:0] dmem_rdata,
    output logic        halted,
    output fault_t      fault_out
);

    logic [31:0] pc;
    logic        stall;
    logic        branch_taken;
    logic [31:0] branch_target;
    src_use_t    src_use;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    dst_t        ex_dst;
    dst_t        mem_dst;
    logic [31:0] mem_result;
    wb_write_t   wb_write;
    logic        fault_retire;
    fault_t      retire_fault;

    always_ff @(posedge SYS_reset or posedge WB_exception_singal)
    begin
        if (WB_exception_singal)
            pc <= RESET_PC;
        else if (branch_taken)
            pc <= branch_target;        // already gated by stall and halt
        else if (!stall && !halted)
            pc <= pc + 32'd4;
    end

    assign imem_addr = pc;

    decode_unit u_decode (
        .SYS_reset (SYS_reset), .WB_exception_singal (WB_exception_singal),
        .imem_data (imem_data), .fetch_pc (pc), .stall (stall), .halted (halted),
        .wb_write (wb_write), .mem_dst (mem_dst), .mem_result (mem_result),
        .src_use (src_use), .id_ex (id_ex),
        .branch_taken (branch_taken), .branch_target (branch_target)
    );

    execute_unit u_execute (
        .SYS_reset (SYS_reset), .WB_exception_singal (WB_exception_singal),
        .halted (halted), .id_ex (id_ex), .ex_dst (ex_dst), .ex_mem (ex_mem)
    );

    mem_wb_unit u_mem_wb (
        .SYS_reset (SYS_reset), .WB_exception_singal (WB_exception_singal),
        .halted (halted), .ex_mem (ex_mem), .dmem_rdata (dmem_rdata),
        .dmem_req (dmem_req), .mem_dst (mem_dst), .mem_result (mem_result),
        .wb_write (wb_write), .fault_retire (fault_retire), .retire_fault (retire_fault)
    );

    hazard_counter u_hazard (
        .SYS_reset (SYS_reset), .WB_exception_singal (WB_exception_singal),
        .halted (halted), .src_use (src_use), .ex_dst (ex_dst), .stall (stall)
    );

    fault_fsm u_fault (
        .SYS_reset (SYS_reset), .WB_exception_singal (WB_exception_singal),
        .fault_retire (fault_retire), .retire_fault (retire_fault),
        .halted (halted), .fault_out (fault_out)
    );

endmodule

// ==== tb/tb_mips_core.sv ====
// Directed testbench for the pipelined core
`timescale 1ns/100ps

module tb_mips_core import cpu_pkg::*;
();

    logic        SYS_reset;
    logic        WB_exception_singal;
    logic [31:0] imem_addr;
    instr_u      imem_data;
    dmem_req_t   dmem_req;
    logic [31:0] dmem_rdata;
    logic        halted;
    fault_t      fault_out;

    logic [31:0] imem [64];         // word 0 sits at RESET_PC
    logic [31:0] init_mem [64];     // data image loaded by each test
    logic [31:0] store_mem [64];    // words written by the core
    logic [63:0] written;           // store_mem entry is valid
    int          store_count;
    logic [31:0] fetch_off;
    logic [31:0] rng;
    int          errors;
    int          test_errors;
    int          checks;
    int          tests_run;
    int          tests_failed;

    mips_core dut (
        .SYS_reset           (SYS_reset),
        .WB_exception_singal (WB_exception_singal),
        .imem_addr           (imem_addr),
        .imem_data           (imem_data),
        .dmem_req            (dmem_req),
        .dmem_rdata          (dmem_rdata),
        .halted              (halted),
        .fault_out           (fault_out)
    );

    always #50 SYS_reset = ~SYS_reset;

    assign fetch_off  = imem_addr - RESET_PC;
    assign imem_data  = (fetch_off[31:8] == 24'd0) ? imem[fetch_off[7:2]] : {6'h3f, 26'd0};
    assign dmem_rdata = written[dmem_req.addr[7:2]] ? store_mem[dmem_req.addr[7:2]]
                                                    : init_mem[dmem_req.addr[7:2]];

    // stores land on the clock edge, the model forgets them on reset
    always @(posedge SYS_reset)
    begin
        if (WB_exception_singal)
        begin
            written     <= '0;
            store_count <= 0;
        end
        else if (dmem_req.we === 1'b1)
        begin
            store_mem[dmem_req.addr[7:2]] <= dmem_req.wdata;
            written[dmem_req.addr[7:2]]   <= 1'b1;
            store_count                   <= store_count + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] r_type(input logic [5:0] funct, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] dmem_fill(input logic [5:0] idx);
        return 32'hdead_0000 ^ {idx, 10'd0, idx, 10'd0};
    endfunction

    function automatic logic [31:0] read_dmem(input logic [5:0] idx);
        return written[idx] ? store_mem[idx] : init_mem[idx];
    endfunction

    function automatic fault_t make_fault(input logic [1:0] cause, input logic [31:0] pc);
        fault_t f;
        f.cause = cause;
        f.pc    = pc;
        return f;
    endfunction

    task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            test_errors++;
            $display("ERR %0t ns: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    task automatic compare_fault(input fault_t got, input fault_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            test_errors++;
            $display("ERR %0t ns: %s expected cause %0d pc %h got cause %0d pc %h",
                     $time, what, exp.cause, exp.pc, got.cause, got.pc);
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            test_errors++;
            $display("ERR %0t ns: %s expected %b got %b", $time, what, exp, got);
        end
    endtask

    // reset goes high and the memories return to their fill patterns
    task automatic assert_reset();
        @(posedge SYS_reset);
        WB_exception_singal <= 1'b1;
        @(negedge SYS_reset);
        for (int i = 0; i < 64; i++)
        begin
            imem[i[5:0]]     = {6'h3f, 14'd0, i[5:0], 6'd0};   // illegal everywhere
            init_mem[i[5:0]] = dmem_fill(i[5:0]);
        end
    endtask

    task automatic release_and_wait(input string name);
        int cycles;
        repeat (3) @(posedge SYS_reset);    // four cycles with the edge in assert_reset
        @(posedge SYS_reset);
        WB_exception_singal <= 1'b0;
        cycles = 0;
        @(negedge SYS_reset);
        while ((halted !== 1'b1) && (cycles < 200))
        begin
            @(negedge SYS_reset);
            cycles++;
        end
        if (halted !== 1'b1)
        begin
            errors++;
            test_errors++;
            $display("timeout: core did not halt within 200 cycles in test %s", name);
        end
    endtask

    task automatic begin_test();
        test_errors = 0;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0)
            $display("test %s: ok", name);
        else
        begin
            tests_failed++;
            $display("test %s: %0d error(s)", name, test_errors);
        end
    endtask

    task automatic test_alu_forwarding();
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        logic [31:0] exp [9];
        begin_test();
        for (int round = 0; round < 3; round++)
        begin
            rng = xorshift32(rng);
            a   = {{2{rng[31]}}, rng[31:2]};    // 30-bit signed keeps sums in range
            rng = xorshift32(rng);
            b   = {{2{rng[31]}}, rng[31:2]};
            rng = xorshift32(rng);
            imm = rng[15:0];
            exp[3] = a + b;
            exp[4] = exp[3] - a;
            exp[5] = exp[4] & a;
            exp[6] = exp[5] | exp[3];
            exp[7] = ($signed(exp[6]) < $signed(a)) ? 32'd1 : 32'd0;
            exp[8] = exp[7] + {{16{imm[15]}}, imm};
            assert_reset();
            init_mem[0] = a;
            init_mem[1] = b;
            imem[0] = i_type(OP_LW, 1, 0, 16'd0);
            imem[1] = i_type(OP_LW, 2, 0, 16'd4);
            imem[2] = r_type(FN_ADD, 3, 1, 2);      // load-use on r2
            imem[3] = r_type(FN_SUB, 4, 3, 1);
            imem[4] = r_type(FN_AND, 5, 4, 1);
            imem[5] = r_type(FN_OR, 6, 5, 3);
            imem[6] = r_type(FN_SLT, 7, 6, 1);
            imem[7] = i_type(OP_ADDI, 8, 7, imm);
            for (int k = 0; k < 6; k++)
                imem[8 + k] = i_type(OP_SW, 5'(3 + k), 0, 16'(16 + 4 * k));
            imem[14] = {6'h3f, 26'd0};
            release_and_wait("alu_forwarding");
            for (int k = 0; k < 6; k++)
                compare_word(read_dmem(6'(4 + k)), exp[3 + k], "stored alu result");
            compare_fault(fault_out, make_fault(FAULT_ILLEGAL, RESET_PC + 32'd56), "end fault");
        end
        end_test("alu_forwarding");
    endtask

    task automatic test_load_use();
        logic [31:0] x;
        logic [15:0] imm;
        begin_test();
        rng = xorshift32(rng);
        x   = {{2{rng[31]}}, rng[31:2]};
        rng = xorshift32(rng);
        imm = rng[15:0];
        assert_reset();
        init_mem[0] = x;
        imem[0] = i_type(OP_ADDI, 2, 0, imm);
        imem[1] = i_type(OP_LW, 1, 0, 16'd0);
        imem[2] = r_type(FN_ADD, 3, 1, 2);          // right behind the load
        imem[3] = i_type(OP_SW, 3, 0, 16'd8);
        imem[4] = {6'h3f, 26'd0};
        release_and_wait("load_use");
        compare_word(read_dmem(6'd2), x + {{16{imm[15]}}, imm}, "load plus operand");
        compare_fault(fault_out, make_fault(FAULT_ILLEGAL, RESET_PC + 32'd16), "end fault");
        end_test("load_use");
    endtask

    task automatic test_branch();
        begin_test();
        assert_reset();
        imem[0]  = i_type(OP_ADDI, 1, 0, 16'd5);
        imem[1]  = i_type(OP_ADDI, 2, 0, 16'd5);
        imem[2]  = i_type(OP_ADDI, 3, 0, 16'd7);
        imem[3]  = i_type(OP_BEQ, 2, 1, 16'd2);     // taken, lands on word 6
        imem[4]  = i_type(OP_SW, 1, 0, 16'd8);      // fetched behind the branch
        imem[5]  = i_type(OP_ADDI, 4, 0, 16'h22);
        imem[6]  = i_type(OP_BEQ, 3, 1, 16'd1);     // 5 vs 7, falls through
        imem[7]  = i_type(OP_ADDI, 5, 0, 16'h33);
        imem[8]  = i_type(OP_SW, 4, 0, 16'd0);
        imem[9]  = i_type(OP_SW, 5, 0, 16'd4);
        imem[10] = {6'h3f, 26'd0};
        release_and_wait("branch");
        compare_word(read_dmem(6'd0), 32'd0, "skipped path marker");
        compare_word(read_dmem(6'd1), 32'h33, "fall-through marker");
        compare_word(read_dmem(6'd2), dmem_fill(6'd2), "squashed store");
        compare_fault(fault_out, make_fault(FAULT_ILLEGAL, RESET_PC + 32'd40), "end fault");
        end_test("branch");
    endtask

    task automatic test_overflow_fault();
        begin_test();
        assert_reset();
        init_mem[0] = 32'h7fff_ffff;
        init_mem[1] = 32'd1;
        imem[0] = i_type(OP_LW, 1, 0, 16'd0);
        imem[1] = i_type(OP_LW, 2, 0, 16'd4);
        imem[2] = r_type(FN_ADD, 3, 1, 2);          // max positive plus one
        imem[3] = i_type(OP_SW, 3, 0, 16'd8);
        imem[4] = {6'h3f, 26'd0};
        release_and_wait("overflow_fault");
        compare_fault(fault_out, make_fault(FAULT_OVERFLOW, RESET_PC + 32'd8), "overflow fault");
        compare_word(read_dmem(6'd2), dmem_fill(6'd2), "store behind fault");
        compare_word(32'(store_count), 32'd0, "store count");
        end_test("overflow_fault");
    endtask

    task automatic test_illegal_opcode();
        begin_test();
        assert_reset();
        imem[0] = i_type(OP_ADDI, 1, 0, 16'd3);
        imem[1] = {6'h02, 26'd0};                   // jump is not implemented
        imem[2] = i_type(OP_SW, 1, 0, 16'd0);
        imem[3] = {6'h3f, 26'd0};
        release_and_wait("illegal_opcode");
        compare_fault(fault_out, make_fault(FAULT_ILLEGAL, RESET_PC + 32'd4), "illegal fault");
        compare_word(read_dmem(6'd0), dmem_fill(6'd0), "store behind fault");
        compare_word(32'(store_count), 32'd0, "store count");
        for (int n = 0; n < 20; n++)
        begin
            @(negedge SYS_reset);
            compare_bit(halted, 1'b1, "halted held");
        end
        assert_reset();
        compare_bit(halted, 1'b0, "halted after reset");
        compare_fault(fault_out, make_fault(FAULT_NONE, 32'd0), "fault after reset");
        end_test("illegal_opcode");
    endtask

    initial
    begin
        SYS_reset           = 1'b0;
        WB_exception_singal = 1'b0;
        rng                 = 32'd65026;
        errors              = 0;
        test_errors         = 0;
        checks              = 0;
        tests_run           = 0;
        tests_failed        = 0;
        test_alu_forwarding();
        test_load_use();
        test_branch();
        test_overflow_fault();
        test_illegal_opcode();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== project.f ====
rtl/cpu_pkg.sv
rtl/hazard_counter.sv
rtl/fault_fsm.sv
rtl/reg_file.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/mem_wb_unit.sv
rtl/mips_core.sv
tb/tb_mips_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_mips_core
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
